// File: hw/nes_pad_pkg.sv
package nes_pad_pkg;

	//////////////////////////////
	// Button word
	//////////////////////////////

	// One bit per button, high when pressed
	// Field order is the order the pad shifts them out
	typedef struct packed
	{
		logic a;
		logic b;
		logic select_b;
		logic start_b;
		logic up;
		logic down;
		logic left;
		logic right;
	} nes_buttons_t;

	//////////////////////////////
	// Timing strobes
	//////////////////////////////

	// Single cycle pulses from the frame timer to the capture block
	typedef struct packed
	{
		// Take the current data bit
		logic sample;
		// Button being sampled, 0 is button a
		logic [2:0] bit_index;
		// All eight bits taken
		logic frame_done;
	} nes_strobe_t;

	//////////////////////////////
	// Frame report
	//////////////////////////////

	typedef struct packed
	{
		nes_buttons_t buttons;
		// Newly pressed since last frame
		nes_buttons_t pressed;
		// Newly released since last frame
		nes_buttons_t released;
	} nes_report_t;

	// Frame timer states
	typedef enum logic [1:0]
	{
		phase_latch,
		phase_low,
		phase_high,
		phase_idle
	} nes_phase_e;

endpackage

// File: hw/nes_pad_timing.sv
`timescale 1ns/1ns

module nes_pad_timing #(
	parameter int LATCH_CYCLES = 1200,
	parameter int HALF_CYCLES = 600,
	parameter int FRAME_CYCLES = 1666667
)(
	input logic clock,
	input logic reset,
	output logic latch,
	output logic pulse,
	output nes_pad_pkg::nes_strobe_t strobe
);

	localparam int FRAME_W = $clog2(FRAME_CYCLES);
	localparam int HALF_W = $clog2(HALF_CYCLES);

	// Counter compare points
	localparam logic [FRAME_W-1:0] FRAME_LAST = FRAME_W'(FRAME_CYCLES - 1);
	localparam logic [FRAME_W-1:0] LATCH_LAST = FRAME_W'(LATCH_CYCLES);
	localparam logic [HALF_W-1:0] HALF_LAST = HALF_W'(HALF_CYCLES - 1);
	// Last cycle of each low half
	localparam logic [HALF_W-1:0] SAMPLE_AT = HALF_W'(HALF_CYCLES - 1);

	logic [FRAME_W-1:0] frame_cnt;
	logic [HALF_W-1:0] half_cnt;
	logic [HALF_W-1:0] half_next;
	logic [2:0] bit_cnt;
	logic [2:0] bit_next;
	nes_pad_pkg::nes_phase_e phase;
	nes_pad_pkg::nes_phase_e phase_next;

	//////////////////////////////
	// Next state
	//////////////////////////////

	always_comb
	begin
		phase_next = phase;
		half_next = half_cnt;
		bit_next = bit_cnt;
		case (phase)
			nes_pad_pkg::phase_idle:
			begin
				// New frame on counter wrap
				if (frame_cnt == '0)
				begin
					phase_next = nes_pad_pkg::phase_latch;
					half_next = '0;
					bit_next = '0;
				end
			end
			nes_pad_pkg::phase_latch:
			begin
				// Latch window measured on the frame counter
				if (frame_cnt == LATCH_LAST)
					phase_next = nes_pad_pkg::phase_low;
			end
			nes_pad_pkg::phase_low:
			begin
				if (half_cnt == HALF_LAST)
				begin
					phase_next = nes_pad_pkg::phase_high;
					half_next = '0;
				end
				else
					half_next = half_cnt + 1'b1;
			end
			default:
			begin
				// High half, then next bit or done
				if (half_cnt == HALF_LAST)
				begin
					half_next = '0;
					if (bit_cnt == 3'd7)
						phase_next = nes_pad_pkg::phase_idle;
					else
					begin
						phase_next = nes_pad_pkg::phase_low;
						bit_next = bit_cnt + 1'b1;
					end
				end
				else
					half_next = half_cnt + 1'b1;
			end
		endcase
	end

	//////////////////////////////
	// State and output registers
	//////////////////////////////

	// Outputs decoded from next state so they line up with phase
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			frame_cnt <= '0;
			phase <= nes_pad_pkg::phase_idle;
			half_cnt <= '0;
			bit_cnt <= '0;
			latch <= 1'b0;
			pulse <= 1'b1;
			strobe <= '0;
		end
		else
		begin
			frame_cnt <= (frame_cnt == FRAME_LAST) ? '0 : frame_cnt + 1'b1;
			phase <= phase_next;
			half_cnt <= half_next;
			bit_cnt <= bit_next;
			latch <= (phase_next == nes_pad_pkg::phase_latch);
			// Pulse idles high, low only in low halves
			pulse <= (phase_next != nes_pad_pkg::phase_low);
			strobe.sample <= (phase_next == nes_pad_pkg::phase_low) && (half_next == SAMPLE_AT);
			strobe.bit_index <= bit_next;
			// Final cycle of the eighth high half
			strobe.frame_done <= (phase_next == nes_pad_pkg::phase_high)
				&& (half_next == HALF_LAST) && (bit_next == 3'd7);
		end
	end

endmodule

// File: hw/nes_pad_receiver.sv
`timescale 1ns/1ns

module nes_pad_receiver (
	input logic clock,
	input logic reset,
	input logic data,
	input nes_pad_pkg::nes_strobe_t strobe,
	output nes_pad_pkg::nes_buttons_t buttons,
	output logic buttons_valid
);

	logic data_meta;
	logic data_sync;
	nes_pad_pkg::nes_buttons_t work;

	//////////////////////////////
	// Data synchronizer
	//////////////////////////////

	// Idle line is high, no button pressed
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			data_meta <= 1'b1;
			data_sync <= 1'b1;
		end
		else
		begin
			data_meta <= data;
			data_sync <= data_meta;
		end
	end

	//////////////////////////////
	// Bit capture
	//////////////////////////////

	// Pad data is active low
	// Bit index 0 lands in the top field
	always_ff @(posedge clock)
	begin
		if (reset)
			work <= '0;
		else if (strobe.sample)
			work[3'd7 - strobe.bit_index] <= ~data_sync;
	end

	// Publish once per frame
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			buttons <= '0;
			buttons_valid <= 1'b0;
		end
		else
		begin
			buttons_valid <= strobe.frame_done;
			if (strobe.frame_done)
				buttons <= work;
		end
	end

endmodule

// File: hw/nes_button_events.sv
`timescale 1ns/1ns

module nes_button_events (
	input logic clock,
	input logic reset,
	input nes_pad_pkg::nes_buttons_t buttons,
	input logic buttons_valid,
	output nes_pad_pkg::nes_report_t report,
	output logic report_valid
);

	// Previous frame, zero after reset
	nes_pad_pkg::nes_buttons_t prev_buttons;

	//////////////////////////////
	// Edge masks
	//////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			prev_buttons <= '0;
			report <= '0;
			report_valid <= 1'b0;
		end
		else
		begin
			report_valid <= buttons_valid;
			if (buttons_valid)
			begin
				report.buttons <= buttons;
				// Set now, clear before
				report.pressed <= nes_pad_pkg::nes_buttons_t'(buttons & ~prev_buttons);
				// Clear now, set before
				report.released <= nes_pad_pkg::nes_buttons_t'(~buttons & prev_buttons);
				prev_buttons <= buttons;
			end
		end
	end

endmodule

// File: hw/nes_pad_top.sv
`timescale 1ns/1ns

module nes_pad_top #(
	// Hardware defaults, about 60 frames per second
	parameter int LATCH_CYCLES = 1200,
	parameter int HALF_CYCLES = 600,
	parameter int FRAME_CYCLES = 1666667
)(
	input logic clock,
	input logic reset,
	// Pad pins
	input logic data,
	output logic latch,
	output logic pulse,
	// Frame report
	output nes_pad_pkg::nes_report_t report,
	output logic report_valid
);

	nes_pad_pkg::nes_strobe_t strobe;
	nes_pad_pkg::nes_buttons_t buttons;
	logic buttons_valid;

	//////////////////////////////
	// Frame timer
	//////////////////////////////

	nes_pad_timing #(
		.LATCH_CYCLES(LATCH_CYCLES),
		.HALF_CYCLES(HALF_CYCLES),
		.FRAME_CYCLES(FRAME_CYCLES)
	) timing (
		.clock(clock),
		.reset(reset),
		.latch(latch),
		.pulse(pulse),
		.strobe(strobe)
	);

	// Serial capture
	nes_pad_receiver receiver (
		.clock(clock),
		.reset(reset),
		.data(data),
		.strobe(strobe),
		.buttons(buttons),
		.buttons_valid(buttons_valid)
	);

	// Press and release detection
	nes_button_events events (
		.clock(clock),
		.reset(reset),
		.buttons(buttons),
		.buttons_valid(buttons_valid),
		.report(report),
		.report_valid(report_valid)
	);

endmodule

// File: testbench/nes_pad_sva.sv
`timescale 1ns/1ns

module nes_pad_sva (
	input logic clock,
	input logic reset,
	input logic latch,
	input logic pulse,
	input nes_pad_pkg::nes_report_t report,
	input logic report_valid
);

	//////////////////////////////
	// Pad link
	//////////////////////////////

	// Pulse stays high through the whole latch window
	latch_with_pulse_high: assert property (@(posedge clock) disable iff (reset)
		latch |-> pulse)
		else $error("latch high while pulse is low");

	//////////////////////////////
	// Report
	//////////////////////////////

	// One cycle strobe per frame
	report_valid_single: assert property (@(posedge clock) disable iff (reset)
		report_valid |=> !report_valid)
		else $error("report_valid high for two cycles in a row");

	// A button cannot be pressed and released in the same frame
	masks_disjoint: assert property (@(posedge clock) disable iff (reset)
		(report.pressed & report.released) == '0)
		else $error("pressed and released share a bit");

	// Newly pressed buttons are held now
	pressed_in_buttons: assert property (@(posedge clock) disable iff (reset)
		(report.pressed & ~report.buttons) == '0)
		else $error("pressed holds a button missing from buttons");

endmodule

// File: testbench/tb_nes_pad.sv
`timescale 1ns/1ns

module tb_nes_pad;

	localparam int LATCH = 12;
	localparam int HALF = 6;
	localparam int FRAME = 200;
	// Latch window, sixteen halves, then capture and report stages
	localparam int FIRST_REPORT = LATCH + 16 * HALF + 2;
	localparam int FRAMES = 40;
	localparam int RESET_FRAME = 20;
	localparam int WATCHDOG_NS = 45 * FRAME * 8;

	logic clock = 1'b0;
	logic reset;
	// Idle pad line is high
	logic data = 1'b1;
	logic latch;
	logic pulse;
	nes_pad_pkg::nes_report_t report;
	logic report_valid;

	// Pad model state
	logic [31:0] rand_state = 32'hfff1;
	logic [7:0] shift_reg = 8'hff;
	logic latch_d = 1'b0;
	logic pulse_d = 1'b1;
	nes_pad_pkg::nes_buttons_t cur_word = '0;
	int frame_num = 0;

	// Monitor state
	nes_pad_pkg::nes_buttons_t exp_prev;
	int cycles, last_report, reports_since_reset, reports_seen = 0;
	int latch_run, low_run, high_run, falls;
	logic latch_q, pulse_q, frame_seen, high_valid;

	nes_pad_top #(
		.LATCH_CYCLES(LATCH),
		.HALF_CYCLES(HALF),
		.FRAME_CYCLES(FRAME)
	) dut (
		.clock(clock),
		.reset(reset),
		.data(data),
		.latch(latch),
		.pulse(pulse),
		.report(report),
		.report_valid(report_valid)
	);

	bind nes_pad_top nes_pad_sva sva (
		.clock(clock),
		.reset(reset),
		.latch(latch),
		.pulse(pulse),
		.report(report),
		.report_valid(report_valid)
	);

	always #4 clock = ~clock;

	// LCG, upper bits are the better ones
	function automatic nes_pad_pkg::nes_buttons_t random_buttons();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return nes_pad_pkg::nes_buttons_t'(rand_state[23:16]);
	endfunction

	task automatic check_value(input string name, input int expected, input int actual);
		assert (expected == actual)
		else
		begin
			$display("Fail %s: expected %0d actual %0d", name, expected, actual);
			$display("*** TEST FAILED ***");
			$fatal(1, "stopped at first error");
		end
	endtask

	//////////////////////////////
	// Pad model, 4021 style
	//////////////////////////////

	always @(posedge clock)
	begin : pad_model
		logic [7:0] next_sr;
		nes_pad_pkg::nes_buttons_t word;
		next_sr = shift_reg;
		word = cur_word;
		// New word on each latch rise, frames 1 and 2 fixed
		if (latch && !latch_d)
		begin
			if (frame_num == 0)
				word = '0;
			else if (frame_num == 1)
				word = '1;
			else
				word = random_buttons();
			cur_word <= word;
			frame_num <= frame_num + 1;
		end
		// Parallel load while latched, active low
		if (latch)
			next_sr = ~word;
		else if (pulse && !pulse_d)
			next_sr = {shift_reg[6:0], 1'b1};
		shift_reg <= next_sr;
		latch_d <= latch;
		pulse_d <= pulse;
		data <= next_sr[7];
	end

	//////////////////////////////
	// Link and report monitor
	//////////////////////////////

	always @(posedge clock)
	begin : monitor
		if (reset)
		begin
			// Fresh frame after reset, previous word zero
			{cycles, last_report, reports_since_reset} = '0;
			{latch_run, low_run, high_run, falls} = '0;
			{latch_q, pulse_q, frame_seen, high_valid} = 4'b0100;
			exp_prev = '0;
		end
		else
		begin
			// Latch window width and pulse count per frame
			if (latch)
				latch_run++;
			if (!latch && latch_q)
			begin
				check_value("link_latch_width", LATCH, latch_run);
				latch_run = 0;
			end
			if (latch && !latch_q)
			begin
				if (frame_seen)
					check_value("link_pulse_count", 8, falls);
				frame_seen = 1'b1;
				falls = 0;
			end
			// Half period widths
			if (!pulse && pulse_q)
			begin
				if (high_valid)
					check_value("link_high_half", HALF, high_run);
				high_valid = 1'b0;
				falls++;
				low_run = 0;
			end
			if (!pulse)
				low_run++;
			if (pulse && !pulse_q)
			begin
				check_value("link_low_half", HALF, low_run);
				high_run = 0;
				high_valid = (falls < 8);
			end
			if (pulse)
				high_run++;
			// Report timing, decode and edge masks
			if (report_valid)
			begin
				if (reports_since_reset == 0)
					check_value("frame_first_report", FIRST_REPORT, cycles);
				else
					check_value("frame_period", FRAME, cycles - last_report);
				last_report = cycles;
				reports_since_reset++;
				reports_seen++;
				check_value("decode_buttons", cur_word, report.buttons);
				check_value("edge_pressed", cur_word & ~exp_prev, report.pressed);
				check_value("edge_released", ~cur_word & exp_prev, report.released);
				exp_prev = cur_word;
			end
			latch_q = latch;
			pulse_q = pulse;
			cycles++;
		end
	end

	//////////////////////////////
	// Sequence
	//////////////////////////////

	initial
	begin
		reset = 1'b1;
		repeat (3) @(posedge clock);
		reset <= 1'b0;
		// Mid-frame reset, during the bit periods of frame 20
		wait (frame_num == RESET_FRAME);
		repeat (50) @(posedge clock);
		reset <= 1'b1;
		@(posedge clock);
		repeat (2)
		begin
			@(posedge clock);
			check_value("reset_latch", 0, latch);
			check_value("reset_pulse", 1, pulse);
			check_value("reset_report_valid", 0, report_valid);
		end
		reset <= 1'b0;
		// Frame 20 never reports
		wait (reports_seen == FRAMES - 1);
		@(posedge clock);
		$display("*** TEST PASSED ***");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout after %0d ns, only %0d reports arrived", WATCHDOG_NS, reports_seen);
		$display("*** TEST FAILED ***");
		$fatal(1, "watchdog expired");
	end

endmodule

// File: flist.f
hw/nes_pad_pkg.sv
hw/nes_pad_timing.sv
hw/nes_pad_receiver.sv
hw/nes_button_events.sv
hw/nes_pad_top.sv
testbench/nes_pad_sva.sv
testbench/tb_nes_pad.sv
